//--- design/clint_timer.sv
// machine timer, timer compare, software interrupt bit and their register access

`timescale 1ns/1ps

module clint_timer (
  input  logic                  clk_i,
  input  logic                  ndmreset_n,
  input  logic                  rtc_i,
  input  soc_map_pkg::reg_req_t reg_req_i,
  output soc_map_pkg::reg_rsp_t reg_rsp_o,
  output logic                  timer_irq_o,
  output logic                  msip_o
);

  soc_map_pkg::reg_data_t mtime_q;
  soc_map_pkg::reg_data_t mtimecmp_q;
  logic                   msip_q;

  logic [1:0] rtc_sync_q;
  logic       rtc_prev_q;
  logic       rtc_div_q;
  logic       rtc_rise;
  logic       mtime_tick;

  logic is_read;
  logic is_write;
  logic hit_msip;
  logic hit_cmp;
  logic hit_time;
  logic hit_any;

  soc_map_pkg::reg_rsp_t rsp_d;
  soc_map_pkg::reg_rsp_t rsp_q;

  // ------------------------------
  // rtc edge detect and divide
  // ------------------------------
  // rtc is a slow async level, sampled on clk_i
  assign rtc_rise   = rtc_sync_q[1] & ~rtc_prev_q;
  // count on every second rising edge
  assign mtime_tick = rtc_rise & rtc_div_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_sync_q <= '0;
      rtc_prev_q <= 1'b0;
      rtc_div_q  <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
      if (rtc_rise) begin
        rtc_div_q <= ~rtc_div_q;
      end
    end
  end

  // ------------------------------
  // address decode
  // ------------------------------
  assign is_read  = (reg_req_i.op == soc_map_pkg::OP_READ);
  assign is_write = (reg_req_i.op == soc_map_pkg::OP_WRITE);
  assign hit_msip = (reg_req_i.addr == soc_map_pkg::MsipOffset);
  assign hit_cmp  = (reg_req_i.addr == soc_map_pkg::MtimecmpOffset);
  assign hit_time = (reg_req_i.addr == soc_map_pkg::MtimeOffset);
  assign hit_any  = hit_msip | hit_cmp | hit_time;

  always_comb begin
    rsp_d       = '0;
    rsp_d.valid = (reg_req_i.op != soc_map_pkg::OP_NOP);
    rsp_d.resp  = soc_map_pkg::RESP_OK;
    if (is_read && hit_msip) begin
      rsp_d.rdata = {63'd0, msip_q};
    end else if (is_read && hit_cmp) begin
      rsp_d.rdata = mtimecmp_q;
    end else if (is_read && hit_time) begin
      rsp_d.rdata = mtime_q;
    end
    // undecoded offset or unknown opcode
    if (rsp_d.valid && (!hit_any || !(is_read || is_write))) begin
      rsp_d.resp  = soc_map_pkg::RESP_ERR;
      rsp_d.rdata = '0;
    end
  end

  // ------------------------------
  // registers
  // ------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
      rsp_q      <= '0;
    end else begin
      rsp_q <= rsp_d;
      // a bus write wins over the rtc increment
      if (is_write && hit_time) begin
        mtime_q <= reg_req_i.wdata;
      end else if (mtime_tick) begin
        mtime_q <= mtime_q + 64'd1;
      end
      if (is_write && hit_cmp) begin
        mtimecmp_q <= reg_req_i.wdata;
      end
      // only bit 0 is implemented
      if (is_write && hit_msip) begin
        msip_q <= reg_req_i.wdata[0];
      end
    end
  end

  assign reg_rsp_o   = rsp_q;
  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign msip_o      = msip_q;

endmodule

//--- design/debug_req_gate.sv
// post-reset hold-off state machine for the debug halt request

`timescale 1ns/1ps

module debug_req_gate #(
  parameter int unsigned DelayCycles = 500
) (
  input  logic clk_i,
  input  logic ndmreset_n,
  input  logic debug_req_i,
  output logic debug_req_o
);

  // at least one counter bit, even for a zero delay
  localparam int unsigned CntWidth = (DelayCycles > 0) ? $clog2(DelayCycles + 1) : 1;

  typedef enum logic {
    GATE_HOLD,
    GATE_OPEN
  } gate_state_e;

  // a zero delay opens the gate straight out of reset
  localparam gate_state_e ResetState = (DelayCycles > 0) ? GATE_HOLD : GATE_OPEN;

  gate_state_e         state_d;
  gate_state_e         state_q;
  logic [CntWidth-1:0] cnt_d;
  logic [CntWidth-1:0] cnt_q;

  // count down while holding, open once the count hits zero
  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    if (state_q == GATE_HOLD) begin
      cnt_d = cnt_q - 1'b1;
      if (cnt_d == '0) begin
        state_d = GATE_OPEN;
      end
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      state_q <= ResetState;
      cnt_q   <= CntWidth'(DelayCycles);
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // boot code runs undisturbed until the gate opens
  assign debug_req_o = (state_q == GATE_OPEN) & debug_req_i;

endmodule

//--- design/hart_irq_ctrl.sv
// top level joining the CLINT timer, debug request gate and hart interrupt router

`timescale 1ns/1ps

module hart_irq_ctrl #(
  parameter int unsigned DelayCycles = hart_irq_pkg::DefaultDelayCycles
) (
  input  logic                              clk_i,
  input  logic                              ndmreset_n,
  input  logic                              rtc_i,
  input  logic                              debug_req_i,
  input  logic [hart_irq_pkg::NrExtIrq-1:0] ext_irq_i,
  input  soc_map_pkg::reg_req_t             reg_req_i,
  output soc_map_pkg::reg_rsp_t             reg_rsp_o,
  output hart_irq_pkg::hart_irq_t           hart_irq_o,
  output hart_irq_pkg::irq_cause_e          cause_o
);

  logic timer_irq;
  logic msip;
  logic debug_req_gated;

  // ------------------------------
  // CLINT
  // ------------------------------
  clint_timer i_clint_timer (
    .clk_i       ( clk_i      ),
    .ndmreset_n  ( ndmreset_n ),
    .rtc_i       ( rtc_i      ),
    .reg_req_i   ( reg_req_i  ),
    .reg_rsp_o   ( reg_rsp_o  ),
    .timer_irq_o ( timer_irq  ),
    .msip_o      ( msip       )
  );

  // ------------------------------
  // debug hold-off
  // ------------------------------
  debug_req_gate #(
    .DelayCycles ( DelayCycles )
  ) i_debug_req_gate (
    .clk_i       ( clk_i           ),
    .ndmreset_n  ( ndmreset_n      ),
    .debug_req_i ( debug_req_i     ),
    .debug_req_o ( debug_req_gated )
  );

  // ------------------------------
  // routing to the hart
  // ------------------------------
  hart_irq_router i_hart_irq_router (
    .clk_i       ( clk_i           ),
    .ndmreset_n  ( ndmreset_n      ),
    .timer_irq_i ( timer_irq       ),
    .msip_i      ( msip            ),
    .debug_req_i ( debug_req_gated ),
    .ext_irq_i   ( ext_irq_i       ),
    .hart_irq_o  ( hart_irq_o      ),
    .cause_o     ( cause_o         )
  );

endmodule

//--- design/hart_irq_pkg.sv
// hart interrupt struct, interrupt cause enum and default debug hold-off delay

package hart_irq_pkg;

  // number of external interrupt lines into the hart
  localparam int unsigned NrExtIrq = 2;

  // cycles the debug request is held off after reset
  // long enough for the boot code to set up a0/a1
  localparam int unsigned DefaultDelayCycles = 500;

  // ------------------------------
  // interrupt word seen by the hart
  // ------------------------------
  typedef struct packed {
    logic                debug;
    logic [NrExtIrq-1:0] ext;
    logic                sw;
    logic                timer;
  } hart_irq_t;

  // ------------------------------
  // pending cause
  // ------------------------------
  // listed from lowest to highest priority
  typedef enum logic [2:0] {
    CAUSE_NONE  = 3'd0,
    CAUSE_TIMER = 3'd1,
    CAUSE_SW    = 3'd2,
    CAUSE_EXT   = 3'd3,
    CAUSE_DEBUG = 3'd4
  } irq_cause_e;

endpackage

//--- design/hart_irq_router.sv
// external interrupt synchronizers, hart interrupt merge register and cause priority encoder

`timescale 1ns/1ps

module hart_irq_router (
  input  logic                                 clk_i,
  input  logic                                 ndmreset_n,
  input  logic                                 timer_irq_i,
  input  logic                                 msip_i,
  input  logic                                 debug_req_i,
  input  logic [hart_irq_pkg::NrExtIrq-1:0]    ext_irq_i,
  output hart_irq_pkg::hart_irq_t              hart_irq_o,
  output hart_irq_pkg::irq_cause_e             cause_o
);

  logic [1:0][hart_irq_pkg::NrExtIrq-1:0] ext_sync_q;

  hart_irq_pkg::hart_irq_t  irq_d;
  hart_irq_pkg::hart_irq_t  irq_q;
  hart_irq_pkg::irq_cause_e cause_d;
  hart_irq_pkg::irq_cause_e cause_q;

  // ------------------------------
  // external line synchronizers
  // ------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      ext_sync_q <= '0;
    end else begin
      ext_sync_q <= {ext_sync_q[0], ext_irq_i};
    end
  end

  // ------------------------------
  // merge and priority
  // ------------------------------
  always_comb begin
    irq_d.debug = debug_req_i;
    irq_d.ext   = ext_sync_q[1];
    irq_d.sw    = msip_i;
    irq_d.timer = timer_irq_i;
  end

  // debug over ext over sw over timer
  always_comb begin
    if (irq_d.debug) begin
      cause_d = hart_irq_pkg::CAUSE_DEBUG;
    end else if (|irq_d.ext) begin
      cause_d = hart_irq_pkg::CAUSE_EXT;
    end else if (irq_d.sw) begin
      cause_d = hart_irq_pkg::CAUSE_SW;
    end else if (irq_d.timer) begin
      cause_d = hart_irq_pkg::CAUSE_TIMER;
    end else begin
      cause_d = hart_irq_pkg::CAUSE_NONE;
    end
  end

  // word and cause change together, so the hart never sees a mix
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      irq_q   <= '0;
      cause_q <= hart_irq_pkg::CAUSE_NONE;
    end else begin
      irq_q   <= irq_d;
      cause_q <= cause_d;
    end
  end

  assign hart_irq_o = irq_q;
  assign cause_o    = cause_q;

endmodule

//--- design/soc_map_pkg.sv
// register map offsets, bus widths, opcode and response enums, request and response structs

package soc_map_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  localparam int unsigned AddrWidth = 16;
  localparam int unsigned DataWidth = 64;

  // byte offset inside the timer block
  typedef logic [AddrWidth-1:0] reg_addr_t;

  // full 64 bit register word
  typedef logic [DataWidth-1:0] reg_data_t;

  // ------------------------------
  // opcodes and response codes
  // ------------------------------
  // OP_NOP marks an idle bus cycle
  typedef enum logic [1:0] {
    OP_NOP   = 2'd0,
    OP_READ  = 2'd1,
    OP_WRITE = 2'd2
  } reg_op_e;

  typedef enum logic {
    RESP_OK  = 1'b0,
    RESP_ERR = 1'b1
  } reg_resp_e;

  // ------------------------------
  // bus structs
  // ------------------------------
  // request, sampled in the cycle it is presented
  typedef struct packed {
    reg_op_e   op;
    reg_addr_t addr;
    reg_data_t wdata;
  } reg_req_t;

  // response, valid for a single cycle
  typedef struct packed {
    logic      valid;
    reg_resp_e resp;
    reg_data_t rdata;
  } reg_rsp_t;

  // ------------------------------
  // register offsets
  // ------------------------------
  localparam reg_addr_t MsipOffset     = 16'h0000;
  localparam reg_addr_t MtimecmpOffset = 16'h4000;
  localparam reg_addr_t MtimeOffset    = 16'hBFF8;

endpackage

//--- dv/hart_irq_ctrl_checker.sv
// concurrent assertions on bus responses and hart interrupt outputs, bound to the top level

`timescale 1ns/1ps

module hart_irq_ctrl_checker (
  input logic                     clk_i,
  input logic                     ndmreset_n,
  input soc_map_pkg::reg_req_t    reg_req_i,
  input soc_map_pkg::reg_rsp_t    reg_rsp_i,
  input hart_irq_pkg::hart_irq_t  hart_irq_i,
  input hart_irq_pkg::irq_cause_e cause_i
);

  // every request gets its response exactly one cycle later
  rsp_after_req: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (reg_req_i.op != soc_map_pkg::OP_NOP) |=> reg_rsp_i.valid)
    else $error("no response one cycle after a bus request");

  no_rsp_when_idle: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (reg_req_i.op == soc_map_pkg::OP_NOP) |=> !reg_rsp_i.valid)
    else $error("response valid without a request one cycle earlier");

  err_without_data: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (reg_rsp_i.valid && (reg_rsp_i.resp == soc_map_pkg::RESP_ERR)) |-> (reg_rsp_i.rdata == '0))
    else $error("error response carries nonzero read data");

  // no cause reported unless some interrupt bit is up
  cause_matches_word: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (cause_i == hart_irq_pkg::CAUSE_NONE) == (hart_irq_i == '0))
    else $error("cause output disagrees with the interrupt word");

endmodule

bind hart_irq_ctrl hart_irq_ctrl_checker i_checker (
  .clk_i      ( clk_i      ),
  .ndmreset_n ( ndmreset_n ),
  .reg_req_i  ( reg_req_i  ),
  .reg_rsp_i  ( reg_rsp_o  ),
  .hart_irq_i ( hart_irq_o ),
  .cause_i    ( cause_o    )
);

//--- dv/hart_irq_ctrl_tb.sv
// testbench with clock, reset, register table, timer and interrupt checks, timeout and verdict

`timescale 1ns/1ps

module hart_irq_ctrl_tb;

  localparam int unsigned DelayCycles   = 20;
  localparam int unsigned RtcEdges      = 6;
  localparam int unsigned RtcPhase      = 8;
  localparam int unsigned NumEntries    = 16;
  localparam int unsigned TimeoutCycles =
    NumEntries * 4 + DelayCycles + RtcEdges * 2 * RtcPhase + 200;

  typedef struct packed {
    soc_map_pkg::reg_op_e   op;
    soc_map_pkg::reg_addr_t addr;
    soc_map_pkg::reg_data_t wdata;
    soc_map_pkg::reg_resp_e exp_resp;
    soc_map_pkg::reg_data_t exp_rdata;
  } table_entry_t;

  logic                              clk_i = 1'b0;
  logic                              ndmreset_n;
  logic                              rtc_i;
  logic                              debug_req_i;
  logic [hart_irq_pkg::NrExtIrq-1:0] ext_irq_i;
  soc_map_pkg::reg_req_t             reg_req_i;
  soc_map_pkg::reg_rsp_t             reg_rsp_o;
  hart_irq_pkg::hart_irq_t           hart_irq_o;
  hart_irq_pkg::irq_cause_e          cause_o;

  table_entry_t stim_table[$];
  int unsigned  cycle_cnt;
  int unsigned  test_errors;
  int unsigned  tests_passed;
  int unsigned  tests_failed;

  hart_irq_ctrl #(
    .DelayCycles ( DelayCycles )
  ) uut (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .debug_req_i ( debug_req_i ),
    .ext_irq_i   ( ext_irq_i   ),
    .reg_req_i   ( reg_req_i   ),
    .reg_rsp_o   ( reg_rsp_o   ),
    .hart_irq_o  ( hart_irq_o  ),
    .cause_o     ( cause_o     )
  );

  always #5 clk_i = ~clk_i;

  // run limit
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TimeoutCycles) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: the run did not finish within %0d cycles", TimeoutCycles);
    $display("TEST FAIL");
    $finish;
  end

  // ------------------------------
  // helpers
  // ------------------------------
  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
      test_errors++;
    end
  endtask

  function automatic hart_irq_pkg::hart_irq_t make_irq(
    input logic debug, input logic [hart_irq_pkg::NrExtIrq-1:0] ext,
    input logic sw, input logic timer);
    hart_irq_pkg::hart_irq_t w;
    w.debug = debug;
    w.ext   = ext;
    w.sw    = sw;
    w.timer = timer;
    return w;
  endfunction

  task automatic check_irq(input hart_irq_pkg::hart_irq_t exp_irq,
                           input hart_irq_pkg::irq_cause_e exp_cause);
    check_value("hart_irq_o", 64'(hart_irq_o), 64'(exp_irq));
    check_value("cause_o", 64'(cause_o), 64'(exp_cause));
  endtask

  // one request, then the response is sampled mid-cycle one cycle later
  task automatic bus_expect(input soc_map_pkg::reg_op_e op, input soc_map_pkg::reg_addr_t addr,
                            input soc_map_pkg::reg_data_t wdata,
                            input soc_map_pkg::reg_resp_e exp_resp,
                            input soc_map_pkg::reg_data_t exp_rdata);
    soc_map_pkg::reg_rsp_t rsp;
    @(posedge clk_i);
    reg_req_i <= '{op: op, addr: addr, wdata: wdata};
    @(posedge clk_i);
    reg_req_i <= '0;
    @(negedge clk_i);
    rsp = reg_rsp_o;
    check_value($sformatf("valid at %h", addr), 64'(rsp.valid), 64'd1);
    check_value($sformatf("resp at %h", addr), 64'(rsp.resp), 64'(exp_resp));
    check_value($sformatf("rdata at %h", addr), rsp.rdata, exp_rdata);
  endtask

  function automatic void add_entry(input soc_map_pkg::reg_op_e op,
                                    input soc_map_pkg::reg_addr_t addr,
                                    input soc_map_pkg::reg_data_t wdata,
                                    input soc_map_pkg::reg_resp_e resp,
                                    input soc_map_pkg::reg_data_t rdata);
    stim_table.push_back('{op: op, addr: addr, wdata: wdata, exp_resp: resp, exp_rdata: rdata});
  endfunction

  task automatic end_test(input string name);
    if (test_errors == 0) begin
      tests_passed++;
      $display("[%0t] %s: passed", $time, name);
    end else begin
      tests_failed++;
      $display("[%0t] %s: failed with %0d errors", $time, name, test_errors);
    end
    test_errors = 0;
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    soc_map_pkg::reg_data_t w_msip;
    soc_map_pkg::reg_data_t w_cmp;
    soc_map_pkg::reg_data_t w_time;
    soc_map_pkg::reg_data_t base;
    void'($urandom(32'ha418));
    ndmreset_n   = 1'b0;
    rtc_i        = 1'b0;
    debug_req_i  = 1'b1;
    ext_irq_i    = '0;
    reg_req_i    = '0;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (8) @(posedge clk_i);
    ndmreset_n <= 1'b1;

    // debug request held high, masked until the gate opens
    repeat (DelayCycles) begin
      @(negedge clk_i);
      check_irq(make_irq(1'b0, 2'b00, 1'b0, 1'b0), hart_irq_pkg::CAUSE_NONE);
    end
    repeat (4) @(negedge clk_i);
    check_irq(make_irq(1'b1, 2'b00, 1'b0, 1'b0), hart_irq_pkg::CAUSE_DEBUG);
    @(posedge clk_i);
    debug_req_i <= 1'b0;
    repeat (4) @(negedge clk_i);
    check_irq(make_irq(1'b0, 2'b00, 1'b0, 1'b0), hart_irq_pkg::CAUSE_NONE);
    end_test("reset and debug hold-off");

    // register table, msip keeps bit 0 only
    w_msip = {$urandom, $urandom} | 64'd1;
    w_cmp  = {$urandom, $urandom};
    w_time = {$urandom, $urandom};
    add_entry(soc_map_pkg::OP_WRITE, soc_map_pkg::MsipOffset, w_msip, soc_map_pkg::RESP_OK, '0);
    add_entry(soc_map_pkg::OP_READ, soc_map_pkg::MsipOffset, '0, soc_map_pkg::RESP_OK,
              {63'd0, w_msip[0]});
    add_entry(soc_map_pkg::OP_WRITE, soc_map_pkg::MsipOffset, '0, soc_map_pkg::RESP_OK, '0);
    add_entry(soc_map_pkg::OP_READ, soc_map_pkg::MsipOffset, '0, soc_map_pkg::RESP_OK, '0);
    add_entry(soc_map_pkg::OP_WRITE, soc_map_pkg::MtimecmpOffset, w_cmp, soc_map_pkg::RESP_OK, '0);
    add_entry(soc_map_pkg::OP_READ, soc_map_pkg::MtimecmpOffset, '0, soc_map_pkg::RESP_OK, w_cmp);
    add_entry(soc_map_pkg::OP_WRITE, soc_map_pkg::MtimecmpOffset, '1, soc_map_pkg::RESP_OK, '0);
    add_entry(soc_map_pkg::OP_READ, soc_map_pkg::MtimecmpOffset, '0, soc_map_pkg::RESP_OK, '1);
    add_entry(soc_map_pkg::OP_WRITE, soc_map_pkg::MtimeOffset, w_time, soc_map_pkg::RESP_OK, '0);
    add_entry(soc_map_pkg::OP_READ, soc_map_pkg::MtimeOffset, '0, soc_map_pkg::RESP_OK, w_time);
    add_entry(soc_map_pkg::OP_READ, 16'h0008, '0, soc_map_pkg::RESP_ERR, '0);
    add_entry(soc_map_pkg::OP_WRITE, 16'h0008, w_cmp, soc_map_pkg::RESP_ERR, '0);
    // rejected writes leave the registers alone
    add_entry(soc_map_pkg::OP_READ, soc_map_pkg::MtimecmpOffset, '0, soc_map_pkg::RESP_OK, '1);
    add_entry(soc_map_pkg::OP_READ, 16'h8000, '0, soc_map_pkg::RESP_ERR, '0);
    add_entry(soc_map_pkg::OP_WRITE, 16'h8000, w_cmp, soc_map_pkg::RESP_ERR, '0);
    add_entry(soc_map_pkg::OP_READ, soc_map_pkg::MtimeOffset, '0, soc_map_pkg::RESP_OK, w_time);
    foreach (stim_table[i]) begin
      bus_expect(stim_table[i].op, stim_table[i].addr, stim_table[i].wdata,
                 stim_table[i].exp_resp, stim_table[i].exp_rdata);
    end
    end_test("register table");

    // six rtc rising edges count mtime up by three
    base = {32'd0, $urandom};
    bus_expect(soc_map_pkg::OP_WRITE, soc_map_pkg::MtimeOffset, base, soc_map_pkg::RESP_OK, '0);
    repeat (RtcEdges) begin
      repeat (RtcPhase) @(posedge clk_i);
      rtc_i <= 1'b1;
      repeat (RtcPhase) @(posedge clk_i);
      rtc_i <= 1'b0;
    end
    repeat (8) @(posedge clk_i);
    bus_expect(soc_map_pkg::OP_READ, soc_map_pkg::MtimeOffset, '0, soc_map_pkg::RESP_OK,
               base + 64'd3);
    end_test("timer counting");

    // compare at mtime fires, far above clears
    bus_expect(soc_map_pkg::OP_WRITE, soc_map_pkg::MtimecmpOffset, base + 64'd3,
               soc_map_pkg::RESP_OK, '0);
    repeat (4) @(negedge clk_i);
    check_irq(make_irq(1'b0, 2'b00, 1'b0, 1'b1), hart_irq_pkg::CAUSE_TIMER);
    bus_expect(soc_map_pkg::OP_WRITE, soc_map_pkg::MtimecmpOffset, base + 64'h100_0000_0000,
               soc_map_pkg::RESP_OK, '0);
    repeat (4) @(negedge clk_i);
    check_irq(make_irq(1'b0, 2'b00, 1'b0, 1'b0), hart_irq_pkg::CAUSE_NONE);
    end_test("timer interrupt");

    // sw, then ext over sw, then debug over all
    bus_expect(soc_map_pkg::OP_WRITE, soc_map_pkg::MsipOffset, 64'd1, soc_map_pkg::RESP_OK, '0);
    repeat (4) @(negedge clk_i);
    check_irq(make_irq(1'b0, 2'b00, 1'b1, 1'b0), hart_irq_pkg::CAUSE_SW);
    @(posedge clk_i);
    ext_irq_i <= 2'b10;
    repeat (4) @(negedge clk_i);
    check_irq(make_irq(1'b0, 2'b10, 1'b1, 1'b0), hart_irq_pkg::CAUSE_EXT);
    @(posedge clk_i);
    debug_req_i <= 1'b1;
    repeat (4) @(negedge clk_i);
    check_irq(make_irq(1'b1, 2'b10, 1'b1, 1'b0), hart_irq_pkg::CAUSE_DEBUG);
    end_test("software and external priority");

    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- hart_irq_ctrl.f
design/soc_map_pkg.sv
design/hart_irq_pkg.sv
design/clint_timer.sv
design/debug_req_gate.sv
design/hart_irq_router.sv
design/hart_irq_ctrl.sv
dv/hart_irq_ctrl_checker.sv
dv/hart_irq_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the hart interrupt controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f hart_irq_ctrl.f \
  --top-module hart_irq_ctrl_tb \
  -o sim_hart_irq_ctrl

out=$(./obj_dir/sim_hart_irq_ctrl)
echo "$out"

if echo "$out" | grep -qx "TEST PASS"; then
  exit 0
else
  exit 1
fi
